/* lsu_macros.svh */
//////////////////////////////////////////////////////////////////////
// Load/store unit sizing
// Data path width and DTIM geometry shared by every stage
//////////////////////////////////////////////////////////////////////

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Hart data and address width
`define LSU_XLEN 32

// Bytes in one data word
`define LSU_BYTES 4

// DTIM depth in words and matching word index width
`define DTIM_WORDS 256
`define DTIM_ADR_BITS 8

`endif

/* lsu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Load/store unit types
// Encodings for memory operation, access size and atomic operation
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // Memory operation from the decoder
  typedef enum logic [1:0] {
    MEM_NONE   = 2'b00,                  // No memory access
    MEM_WRITE  = 2'b01,                  // Store
    MEM_READ   = 2'b10,                  // Load
    MEM_ATOMIC = 2'b11                   // Reserved, behaves as none
  } memRwT;

  // Access size, straight from funct3
  typedef enum logic [2:0] {
    SIZE_B  = 3'b000,
    SIZE_H  = 3'b001,
    SIZE_W  = 3'b010,
    SIZE_BU = 3'b100,
    SIZE_HU = 3'b101
  } accessSizeT;

  // Only LR.W and SC.W survive from the A extension
  typedef enum logic [1:0] {
    ATOM_NONE = 2'b00,
    ATOM_LR   = 2'b01,
    ATOM_SC   = 2'b10
  } atomicOpT;

endpackage

/* lsuIssueStage.sv */
//////////////////////////////////////////////////////////////////////
// LSU issue stage
// Execute-to-memory pipeline register for address and controls.
// Alignment is checked in E and carried into M as registered
// fault flags plus a single access valid bit.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsuIssueStage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  StallM,                   // Hold M stage
  input  logic                  FlushM,                   // Turn M stage into a bubble
  input  logic [`LSU_XLEN-1:0]  IEUAdrE,                  // Effective address from the ALU
  input  lsu_pkg::memRwT        MemRWE,
  input  lsu_pkg::accessSizeT   Funct3E,
  input  lsu_pkg::atomicOpT     AtomicE,
  output logic [`LSU_XLEN-1:0]  IEUAdrM,
  output lsu_pkg::memRwT        MemRWM,
  output lsu_pkg::accessSizeT   Funct3M,
  output lsu_pkg::atomicOpT     AtomicM,
  output logic                  LoadMisalignedFaultM,
  output logic                  StoreAmoMisalignedFaultM,
  output logic                  accessValidM              // Aligned load or store in M
);
  import lsu_pkg::*;

  logic halfAccessE;                                      // Halfword of either sign
  logic wordAccessE;
  logic misalignedE;
  logic readE;
  logic writeE;

  //////////////////////////////////////////////////////////////////////
  // Alignment check in E
  //////////////////////////////////////////////////////////////////////

  assign halfAccessE = (Funct3E == SIZE_H) || (Funct3E == SIZE_HU);
  assign wordAccessE = (Funct3E == SIZE_W);
  assign misalignedE = (halfAccessE && IEUAdrE[0]) ||
                       (wordAccessE && (IEUAdrE[1:0] != 2'b00));

  assign readE  = (MemRWE == MEM_READ);                   // LR arrives here as a read
  assign writeE = (MemRWE == MEM_WRITE);                  // SC arrives here as a write

  //////////////////////////////////////////////////////////////////////
  // E to M register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || FlushM) begin                              // Flush wins over stall
      IEUAdrM                  <= '0;
      MemRWM                   <= MEM_NONE;
      Funct3M                  <= SIZE_B;
      AtomicM                  <= ATOM_NONE;
      LoadMisalignedFaultM     <= 1'b0;
      StoreAmoMisalignedFaultM <= 1'b0;
      accessValidM             <= 1'b0;
    end else if (!StallM) begin
      IEUAdrM                  <= IEUAdrE;
      MemRWM                   <= MemRWE;
      Funct3M                  <= Funct3E;
      AtomicM                  <= AtomicE;
      LoadMisalignedFaultM     <= readE && misalignedE;
      StoreAmoMisalignedFaultM <= writeE && misalignedE;
      accessValidM             <= (readE || writeE) && !misalignedE; // MEM_ATOMIC never valid
    end
  end

endmodule

/* storeFormat.sv */
//////////////////////////////////////////////////////////////////////
// Store data formatter
// Replicates byte and halfword data over the word, builds the byte
// write mask and applies the optional big-endian swap
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module storeFormat (
  input  logic [`LSU_XLEN-1:0]   WriteDataM,             // Register operand from the IEU
  input  lsu_pkg::accessSizeT    Funct3M,
  input  logic [1:0]             adrLowM,                // Byte offset within the word
  input  logic                   BigEndianM,
  output logic [`LSU_XLEN-1:0]   storeDataM,
  output logic [`LSU_BYTES-1:0]  byteMaskM
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0]  leDataM;                        // Little-endian replicated data
  logic [`LSU_BYTES-1:0] leMaskM;

  // Replication puts the subword in every lane so the mask alone picks the target
  always_comb begin
    case (Funct3M)
      SIZE_B, SIZE_BU: begin
        leDataM = {`LSU_BYTES{WriteDataM[7:0]}};
        leMaskM = `LSU_BYTES'(1) << adrLowM;
      end
      SIZE_H, SIZE_HU: begin
        leDataM = {(`LSU_BYTES/2){WriteDataM[15:0]}};
        leMaskM = `LSU_BYTES'(3) << {adrLowM[1], 1'b0}; // Low bit ignored, faults catch it
      end
      default: begin                                     // Full word
        leDataM = WriteDataM;
        leMaskM = '1;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Big-endian lane reversal
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    storeDataM = leDataM;
    byteMaskM  = leMaskM;
    if (BigEndianM) begin
      for (int i = 0; i < `LSU_BYTES; i++) begin
        storeDataM[8*i +: 8] = leDataM[8*(`LSU_BYTES-1-i) +: 8];
        byteMaskM[i]         = leMaskM[`LSU_BYTES-1-i];  // Mask follows its data byte
      end
    end
  end

endmodule

/* lrscUnit.sv */
//////////////////////////////////////////////////////////////////////
// LR/SC reservation tracker
// Holds one word reservation, resolves store-conditional success
// and produces the final DTIM write enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lrscUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  StallW,
  input  logic                  FlushW,
  input  lsu_pkg::memRwT        MemRWM,
  input  lsu_pkg::atomicOpT     AtomicM,
  input  logic                  accessValidM,
  input  logic [`LSU_XLEN-3:0]  wordAdrM,               // Address without the byte offset
  output logic                  dtimWriteEn,
  output logic                  SquashSCW               // SC failed, GPR write gets 1
);
  import lsu_pkg::*;

  logic                 resValid;
  logic [`LSU_XLEN-3:0] resAdr;
  logic                 lrM;
  logic                 scM;
  logic                 scSuccessM;
  logic                 commitM;                        // Pipeline lets M take effect

  assign commitM    = !StallW && !FlushW;
  assign lrM        = (MemRWM == MEM_READ) && (AtomicM == ATOM_LR);
  assign scM        = (MemRWM == MEM_WRITE) && (AtomicM == ATOM_SC);
  assign scSuccessM = resValid && (resAdr == wordAdrM);

  // Plain stores always write, SC only on a matching reservation
  assign dtimWriteEn = accessValidM && (MemRWM == MEM_WRITE) && commitM &&
                       (!scM || scSuccessM);

  //////////////////////////////////////////////////////////////////////
  // Reservation register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
    end else if (commitM) begin
      if (scM) resValid <= 1'b0;                        // Any SC consumes it
      else if (lrM && accessValidM) resValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (commitM && lrM && accessValidM) resAdr <= wordAdrM;
  end

  // SC outcome lines up with ReadDataW
  always_ff @(posedge clk) begin
    if (rst) SquashSCW <= 1'b0;
    else if (!StallW) SquashSCW <= scM && !scSuccessM;
  end

endmodule

/* dtimRam.sv */
//////////////////////////////////////////////////////////////////////
// Data tightly integrated memory
// Byte-writable word array, written on the clock edge and read
// combinationally from the M-stage word index
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module dtimRam (
  input  logic                      clk,
  input  logic                      dtimWriteEn,
  input  logic [`DTIM_ADR_BITS-1:0] wordIdxM,
  input  logic [`LSU_BYTES-1:0]     byteMaskM,
  input  logic [`LSU_XLEN-1:0]      storeDataM,
  output logic [`LSU_XLEN-1:0]      readWordM
);

  logic [`LSU_XLEN-1:0] mem [`DTIM_WORDS];              // Contents undefined after reset

  // Masked byte lanes only
  always_ff @(posedge clk) begin
    if (dtimWriteEn) begin
      for (int i = 0; i < `LSU_BYTES; i++) begin
        if (byteMaskM[i]) mem[wordIdxM][8*i +: 8] <= storeDataM[8*i +: 8];
      end
    end
  end

  assign readWordM = mem[wordIdxM];                     // Same-cycle read

endmodule

/* loadFormat.sv */
//////////////////////////////////////////////////////////////////////
// Load data formatter
// Undoes the big-endian swap, picks the addressed byte or
// halfword, extends it and registers the result into W
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module loadFormat (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  StallW,
  input  logic [`LSU_XLEN-1:0]  readWordM,              // Raw DTIM word
  input  logic [1:0]            adrLowM,
  input  lsu_pkg::accessSizeT   Funct3M,
  input  logic                  BigEndianM,
  output logic [`LSU_XLEN-1:0]  ReadDataW
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] leWordM;                        // Word in hart byte order
  logic [7:0]           byteM;
  logic [15:0]          halfM;
  logic [`LSU_XLEN-1:0] readDataM;

  always_comb begin
    leWordM = readWordM;
    if (BigEndianM) begin
      for (int i = 0; i < `LSU_BYTES; i++)
        leWordM[8*i +: 8] = readWordM[8*(`LSU_BYTES-1-i) +: 8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane select and extension
  //////////////////////////////////////////////////////////////////////

  assign byteM = leWordM[{adrLowM, 3'b000} +: 8];
  assign halfM = leWordM[{adrLowM[1], 4'b0000} +: 16];  // Upper or lower half

  always_comb begin
    case (Funct3M)
      SIZE_B:  readDataM = {{(`LSU_XLEN-8){byteM[7]}}, byteM};
      SIZE_BU: readDataM = {{(`LSU_XLEN-8){1'b0}}, byteM};
      SIZE_H:  readDataM = {{(`LSU_XLEN-16){halfM[15]}}, halfM};
      SIZE_HU: readDataM = {{(`LSU_XLEN-16){1'b0}}, halfM};
      default: readDataM = leWordM;                     // Word load
    endcase
  end

  // M to W read data register
  always_ff @(posedge clk) begin
    if (rst) ReadDataW <= '0;
    else if (!StallW) ReadDataW <= readDataM;
  end

endmodule

/* lsu.sv */
//////////////////////////////////////////////////////////////////////
// Load/store unit top
// Issue register, store formatting, LR/SC, DTIM and load
// formatting chained from E through M into W
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  StallM,
  input  logic                  FlushM,
  input  logic                  StallW,
  input  logic                  FlushW,
  // Execute stage request
  input  logic [`LSU_XLEN-1:0]  IEUAdrE,
  input  lsu_pkg::memRwT        MemRWE,
  input  lsu_pkg::accessSizeT   Funct3E,
  input  lsu_pkg::atomicOpT     AtomicE,
  // Memory stage data and mode
  input  logic [`LSU_XLEN-1:0]  WriteDataM,
  input  logic                  BigEndianM,
  output logic [`LSU_XLEN-1:0]  IEUAdrM,
  output logic [`LSU_XLEN-1:0]  ReadDataW,
  output logic                  SquashSCW,
  output logic                  LoadMisalignedFaultM,
  output logic                  StoreAmoMisalignedFaultM
);
  import lsu_pkg::*;

  memRwT                 MemRWM;
  accessSizeT            Funct3M;
  atomicOpT              AtomicM;
  logic                  accessValidM;                  // Aligned load or store
  logic [`LSU_XLEN-1:0]  storeDataM;
  logic [`LSU_BYTES-1:0] byteMaskM;
  logic                  dtimWriteEn;
  logic [`LSU_XLEN-1:0]  readWordM;

  //////////////////////////////////////////////////////////////////////
  // E to M
  //////////////////////////////////////////////////////////////////////

  lsuIssueStage u_issue (
    .clk, .rst, .StallM, .FlushM,
    .IEUAdrE, .MemRWE, .Funct3E, .AtomicE,
    .IEUAdrM, .MemRWM, .Funct3M, .AtomicM,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM, .accessValidM
  );

  //////////////////////////////////////////////////////////////////////
  // Memory access and M to W
  //////////////////////////////////////////////////////////////////////

  storeFormat u_storeFmt (
    .WriteDataM, .Funct3M, .adrLowM(IEUAdrM[1:0]), .BigEndianM,
    .storeDataM, .byteMaskM
  );

  lrscUnit u_lrsc (
    .clk, .rst, .StallW, .FlushW, .MemRWM, .AtomicM, .accessValidM,
    .wordAdrM(IEUAdrM[`LSU_XLEN-1:2]),                  // Reservation granule is one word
    .dtimWriteEn, .SquashSCW
  );

  dtimRam u_dtim (
    .clk, .dtimWriteEn,
    .wordIdxM(IEUAdrM[`DTIM_ADR_BITS+1:2]),             // Upper address bits alias
    .byteMaskM, .storeDataM, .readWordM
  );

  loadFormat u_loadFmt (
    .clk, .rst, .StallW, .readWordM, .adrLowM(IEUAdrM[1:0]),
    .Funct3M, .BigEndianM, .ReadDataW
  );

endmodule

/* lsu_sva.sv */
//////////////////////////////////////////////////////////////////////
// LSU internal checks
// Fault exclusivity, DTIM write gating and SC squash origin
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsuSva (
  input logic                clk,
  input logic                rst,
  input logic                StallW,
  input lsu_pkg::memRwT      MemRWM,
  input lsu_pkg::accessSizeT Funct3M,
  input lsu_pkg::atomicOpT   AtomicM,
  input logic [1:0]          adrLowM,                  // Byte offset of the M-stage address
  input logic                accessValidM,
  input logic                dtimWriteEn,
  input logic                SquashSCW,
  input logic                LoadMisalignedFaultM,
  input logic                StoreAmoMisalignedFaultM
);
  import lsu_pkg::*;

  int   errCount = 0;                                   // Failed assertion count
  logic scM;
  logic alignedM;                                       // Natural alignment of the op in M

  assign scM = (MemRWM == MEM_WRITE) && (AtomicM == ATOM_SC);

  always_comb begin
    case (Funct3M)
      SIZE_H, SIZE_HU: alignedM = !adrLowM[0];
      SIZE_W:          alignedM = (adrLowM == 2'b00);
      default:         alignedM = 1'b1;
    endcase
  end

  faultsExclusive: assert property (@(posedge clk) disable iff (rst)
    !(LoadMisalignedFaultM && StoreAmoMisalignedFaultM))
    else begin
      errCount++;
      $error("Load and store misaligned faults high together");
    end

  // Misaligned or empty slots never reach the array
  writeNeedsValid: assert property (@(posedge clk) disable iff (rst)
    dtimWriteEn |-> (accessValidM && alignedM))
    else begin
      errCount++;
      $error("DTIM write without a valid access");
    end

  squashFromSc: assert property (@(posedge clk) disable iff (rst)
    SquashSCW |-> ($past(scM) || $past(StallW)))       // Held value under stall
    else begin
      errCount++;
      $error("SquashSCW raised without an SC in M");
    end

endmodule

bind lsu lsuSva u_sva (
  .clk, .rst, .StallW, .MemRWM, .Funct3M, .AtomicM, .adrLowM(IEUAdrM[1:0]),
  .accessValidM, .dtimWriteEn, .SquashSCW,
  .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM
);

/* tb_lsu.sv */
//////////////////////////////////////////////////////////////////////
// LSU testbench
// Directed and random loads, stores and LR/SC checked against a
// byte-level DTIM model at fixed pipeline offsets
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu;
  import lsu_pkg::*;

  localparam int WORDS          = 32;                   // DTIM window under test
  localparam int NUM_RANDOM     = 200;
  localparam int TIMEOUT_CYCLES = (2 * WORDS + NUM_RANDOM + 20) * 8; // Op takes 5 at most

  logic        clk = 1'b0;
  logic        rst;
  logic        stall;                                   // StallM and StallW together
  logic        FlushM;
  logic        FlushW;
  logic        BigEndianM;
  logic [31:0] IEUAdrE;
  logic [31:0] WriteDataM;
  memRwT       MemRWE;
  accessSizeT  Funct3E;
  atomicOpT    AtomicE;
  logic [31:0] IEUAdrM;
  logic [31:0] ReadDataW;
  logic        SquashSCW;
  logic        LoadMisalignedFaultM;
  logic        StoreAmoMisalignedFaultM;

  logic [7:0]  refMem [4*WORDS];                        // Byte model, physical lanes
  bit          resValid = 1'b0;
  int          resWord;
  int          cycleCount = 0;
  accessSizeT  sizes [5] = '{SIZE_B, SIZE_H, SIZE_W, SIZE_BU, SIZE_HU};

  lsu i_dut (
    .clk, .rst, .StallM(stall), .FlushM, .StallW(stall), .FlushW,
    .IEUAdrE, .MemRWE, .Funct3E, .AtomicE, .WriteDataM, .BigEndianM,
    .IEUAdrM, .ReadDataW, .SquashSCW, .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM
  );

  initial forever #5 clk = ~clk;

  always @(posedge clk) cycleCount <= cycleCount + 1;

  initial begin
    wait (cycleCount >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "Timeout");
  end

  initial begin
    wait (i_dut.u_sva.errCount != 0);
    $display("Error at %0t ns: a bound assertion on the LSU internals failed", $time);
    $display("Simulation failed");
    $fatal(1, "Bound assertion failure");
  end

  function automatic int sizeBytes(accessSizeT sz);
    case (sz)
      SIZE_B, SIZE_BU: return 1;
      SIZE_H, SIZE_HU: return 2;
      default:         return 4;
    endcase
  endfunction

  // Hart byte offset to the lane it occupies in the DTIM word
  function automatic int physLane(int hartByte, logic be);
    return be ? 3 - hartByte : hartByte;
  endfunction

  task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    $display("Simulation failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One operation from E to W, with optional flushes and stalls in M
  //////////////////////////////////////////////////////////////////////

  task automatic issueOp(memRwT rw, accessSizeT sz, atomicOpT at, int word, int off,
                         logic [31:0] wd, logic be, logic flM, logic flW, int stalls);
    int          n;
    bit          misaligned;
    bit          scOp;
    bit          scOk;
    bit          doWrite;
    bit          expLdFault;
    bit          expStFault;
    logic [31:0] expAdr;
    logic [31:0] expRd;
    logic [31:0] heldRd;
    n          = sizeBytes(sz);
    misaligned = (off % n) != 0;
    scOp       = (rw == MEM_WRITE) && (at == ATOM_SC) && !flM;
    scOk       = resValid && (resWord == word);
    doWrite    = (rw == MEM_WRITE) && !misaligned && !flM && !flW && (!scOp || scOk);
    expAdr     = 32'(word * 4 + off);
    expLdFault = (rw == MEM_READ) && misaligned && !flM;
    expStFault = (rw == MEM_WRITE) && misaligned && !flM;
    expRd      = '0;
    if (!misaligned) begin
      for (int k = 0; k < n; k++) expRd[8*k +: 8] = refMem[4*word + physLane(off + k, be)];
    end
    if (sz == SIZE_B) expRd = {{24{expRd[7]}}, expRd[7:0]};
    if (sz == SIZE_H) expRd = {{16{expRd[15]}}, expRd[15:0]};

    @(posedge clk);                                     // Cycle t, op in E
    IEUAdrE    <= expAdr;
    MemRWE     <= rw;
    Funct3E    <= sz;
    AtomicE    <= at;
    WriteDataM <= wd;
    BigEndianM <= be;
    FlushM     <= flM;
    @(posedge clk);                                     // Cycle t+1, op in M
    MemRWE  <= MEM_NONE;
    AtomicE <= ATOM_NONE;
    FlushM  <= 1'b0;
    FlushW  <= flW;
    stall   <= (stalls > 0);
    @(negedge clk);
    assert (LoadMisalignedFaultM === expLdFault)
      else reportMismatch("LoadMisalignedFaultM", expLdFault, LoadMisalignedFaultM);
    assert (StoreAmoMisalignedFaultM === expStFault)
      else reportMismatch("StoreAmoMisalignedFaultM", expStFault, StoreAmoMisalignedFaultM);
    if (!flM) begin                                     // Address of the op now in M
      assert (IEUAdrM === expAdr) else reportMismatch("IEUAdrM", expAdr, IEUAdrM);
    end
    heldRd = ReadDataW;
    for (int i = 0; i < stalls; i++) begin
      @(posedge clk);
      if (i == stalls - 1) stall <= 1'b0;
      @(negedge clk);
      assert (ReadDataW === heldRd) else reportMismatch("ReadDataW", heldRd, ReadDataW);
    end
    @(posedge clk);                                     // Write and reservation edge
    FlushW <= 1'b0;
    if (doWrite) begin
      for (int k = 0; k < n; k++) refMem[4*word + physLane(off + k, be)] = wd[8*k +: 8];
    end
    if (!flM && !flW) begin
      if (scOp) resValid = 1'b0;                        // Any SC drops it
      else if (rw == MEM_READ && at == ATOM_LR && !misaligned) begin
        resValid = 1'b1;
        resWord  = word;
      end
    end
    @(negedge clk);                                     // Cycle t+2, result in W
    if (rw == MEM_READ && !misaligned && !flM) begin
      assert (ReadDataW === expRd) else reportMismatch("ReadDataW", expRd, ReadDataW);
    end
    assert (SquashSCW === (scOp && !scOk))
      else reportMismatch("SquashSCW", scOp && !scOk, SquashSCW);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    memRwT      rw;
    accessSizeT sz;
    int         off;
    void'($urandom(32'hcbe8));
    rst        = 1'b1;
    stall      = 1'b0;
    FlushM     = 1'b0;
    FlushW     = 1'b0;
    BigEndianM = 1'b0;
    IEUAdrE    = '0;
    WriteDataM = '0;
    MemRWE     = MEM_NONE;
    Funct3E    = SIZE_W;
    AtomicE    = ATOM_NONE;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert ({LoadMisalignedFaultM, StoreAmoMisalignedFaultM, SquashSCW} === 3'b000)
      else reportMismatch("reset flags", 0, {LoadMisalignedFaultM, StoreAmoMisalignedFaultM,
                                              SquashSCW});

    for (int w = 0; w < WORDS; w++) begin
      issueOp(MEM_WRITE, SIZE_W, ATOM_NONE, w, 0, $urandom, 0, 0, 0, 0);
    end

    // LR/SC: no reservation, match, SC after SC, other word
    issueOp(MEM_WRITE, SIZE_W, ATOM_SC, 3, 0, $urandom, 0, 0, 0, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_LR, 3, 0, 0,        0, 0, 0, 0);
    issueOp(MEM_WRITE, SIZE_W, ATOM_SC, 3, 0, $urandom, 0, 0, 0, 0);
    issueOp(MEM_WRITE, SIZE_W, ATOM_SC, 3, 0, $urandom, 0, 0, 0, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_LR, 5, 0, 0,        0, 0, 0, 0);
    issueOp(MEM_WRITE, SIZE_W, ATOM_SC, 6, 0, $urandom, 0, 0, 0, 0);

    // Big-endian store, read back in both modes
    issueOp(MEM_WRITE, SIZE_W, ATOM_NONE, 7, 0, 32'h11223344, 1, 0, 0, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_NONE, 7, 0, 0, 0, 0, 0, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_NONE, 7, 0, 0, 1, 0, 0, 0);

    // Misaligned halfword and word, both directions
    issueOp(MEM_READ,  SIZE_H, ATOM_NONE, 8, 1, 0, 0, 0, 0, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_NONE, 8, 2, 0, 0, 0, 0, 0);
    issueOp(MEM_WRITE, SIZE_H, ATOM_NONE, 8, 3, $urandom, 0, 0, 0, 0);
    issueOp(MEM_WRITE, SIZE_W, ATOM_NONE, 8, 1, $urandom, 0, 0, 0, 0);

    // Flushed stores in E and M, then a stalled load
    issueOp(MEM_WRITE, SIZE_W, ATOM_NONE, 9, 0, $urandom, 0, 1, 0, 0);
    issueOp(MEM_WRITE, SIZE_W, ATOM_NONE, 9, 0, $urandom, 0, 0, 1, 0);
    issueOp(MEM_READ,  SIZE_W, ATOM_NONE, 9, 0, 0, 0, 0, 0, 2);

    repeat (NUM_RANDOM) begin
      sz  = sizes[$urandom_range(0, 4)];
      rw  = $urandom_range(0, 1) ? MEM_WRITE : MEM_READ;
      off = $urandom_range(0, 3);
      if ($urandom_range(0, 3) != 0) off = off & ~(sizeBytes(sz) - 1); // Mostly aligned
      issueOp(rw, sz, ATOM_NONE, $urandom_range(0, WORDS - 1), off, $urandom,
              $urandom_range(0, 1), $urandom_range(0, 15) == 0,
              (rw == MEM_WRITE) && ($urandom_range(0, 15) == 0), $urandom_range(0, 2));
    end

    for (int w = 0; w < WORDS; w++) begin
      issueOp(MEM_READ, SIZE_W, ATOM_NONE, w, 0, 0, 0, 0, 0, 0);
    end

    if (i_dut.u_sva.errCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Bound assertion failure");
    end
  end

endmodule

/* filelist.f */
+incdir+.
lsu_pkg.sv
lsuIssueStage.sv
storeFormat.sv
lrscUnit.sv
dtimRam.sv
loadFormat.sv
lsu.sv
lsu_sva.sv
tb_lsu.sv
